// ==== hdl/rvv_backend_settings.svh ====
/*
  RVV backend ALU slice settings
  lane count, station depth and datapath widths
*/
`ifndef RVV_BACKEND_SETTINGS_SVH
`define RVV_BACKEND_SETTINGS_SVH

// ALU lanes; the wrapper pop rule only handles two
`define NUM_ALU_UOP 2

// reservation station entries
`define ALU_RS_DEPTH 8

// data chunk handled by one micro-op
`define VLENB_CHUNK 32

// ROB tag width
`define ROB_ENTRY_W 4

`endif

// ==== hdl/rvv_backend_pkg.sv ====
/*
  RVV backend ALU types
  opcode and element width encodings, micro-op and ROB result records
*/
`include "rvv_backend_settings.svh"

package rvv_backend_pkg;

  // ALU operations, codes 9..15 are unused
  typedef enum logic [3:0] {
    op_add  = 4'd0,
    op_sub  = 4'd1,
    op_and  = 4'd2,
    op_or   = 4'd3,
    op_xor  = 4'd4,
    op_sll  = 4'd5,
    op_srl  = 4'd6,
    op_minu = 4'd7,
    op_maxu = 4'd8
  } alu_opcode_e;

  // element width, code 3 is unused
  typedef enum logic [1:0] {
    sew_e8  = 2'd0,
    sew_e16 = 2'd1,
    sew_e32 = 2'd2
  } sew_e;

  // micro-op held in the reservation station
  typedef struct packed {
    logic [`ROB_ENTRY_W-1:0] rob_entry;
    alu_opcode_e             opcode;
    sew_e                    sew;
    logic [`VLENB_CHUNK-1:0] vs2_data;
    logic [`VLENB_CHUNK-1:0] vs1_data;
  } alu_rs_t;

  // result written back through the ROB
  typedef struct packed {
    logic [`ROB_ENTRY_W-1:0] rob_entry;
    logic [`VLENB_CHUNK-1:0] w_data;
  } alu2rob_t;

endpackage

// ==== hdl/rvv_backend_alu_rs.sv ====
/*
  ALU reservation station
  in-order circular buffer, one push and up to two pops per cycle,
  the two oldest entries are offered to the execution lanes
*/
`timescale 1ns/1ps
`include "rvv_backend_settings.svh"

module rvv_backend_alu_rs
  import rvv_backend_pkg::*;
(
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         push_valid,
  input  alu_rs_t                      push_uop,
  output logic                         push_ready,
  output alu_rs_t [`NUM_ALU_UOP-1:0]   uop_out,
  output logic                         fifo_empty,
  output logic                         fifo_1left_to_empty,
  input  logic    [`NUM_ALU_UOP-1:0]   pop
);

  localparam int PTR_W = $clog2(`ALU_RS_DEPTH);
  localparam int CNT_W = $clog2(`ALU_RS_DEPTH + 1);

  alu_rs_t           mem [`ALU_RS_DEPTH];
  logic [PTR_W-1:0]  wptr;
  logic [PTR_W-1:0]  rptr;
  logic [CNT_W-1:0]  count;
  logic              push_fire;
  logic [1:0]        pop_num;

  // pointer advance with wrap at the station depth
  function automatic logic [PTR_W-1:0] ptr_add(logic [PTR_W-1:0] ptr, int unsigned inc);
    int unsigned sum;
    sum = ptr + inc;
    if (sum >= `ALU_RS_DEPTH)
      sum = sum - `ALU_RS_DEPTH;
    return PTR_W'(sum);
  endfunction

  assign push_ready          = (count != CNT_W'(`ALU_RS_DEPTH));
  assign push_fire           = push_valid && push_ready;
  assign pop_num             = {1'b0, pop[0]} + {1'b0, pop[1]};
  assign fifo_empty          = (count == '0);
  assign fifo_1left_to_empty = (count == CNT_W'(1));

  // oldest entry on lane 0, next one on lane 1
  assign uop_out[0] = mem[rptr];
  assign uop_out[1] = mem[ptr_add(rptr, 1)];

  always_ff @(posedge clk) begin
    if (push_fire)
      mem[wptr] <= push_uop;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wptr  <= '0;
      rptr  <= '0;
      count <= '0;
    end else begin
      if (push_fire)
        wptr <= ptr_add(wptr, 1);
      rptr  <= ptr_add(rptr, pop_num);
      count <= count + CNT_W'(push_fire) - CNT_W'(pop_num);
    end
  end

  a_pop0_not_empty: assert property (@(posedge clk) disable iff (!rst_n)
    pop[0] |-> !fifo_empty)
    else $error("ALU RS: lane 0 popped while empty");

  a_pop1_in_order: assert property (@(posedge clk) disable iff (!rst_n)
    pop[1] |-> pop[0] && (count >= CNT_W'(2)))
    else $error("ALU RS: lane 1 popped out of order or past the held entries");

  // a push never lands on an entry still held
  a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
    push_fire && !fifo_empty |-> (wptr != rptr))
    else $error("ALU RS: push would overwrite a held entry");

endmodule

// ==== hdl/rvv_backend_alu_unit.sv ====
/*
  ALU execution unit
  decodes one micro-op and computes add/sub/logic/shift/min/max
  lane-wise on 8, 16 or 32 bit elements of a data chunk
*/
`timescale 1ns/1ps
`include "rvv_backend_settings.svh"

module rvv_backend_alu_unit
  import rvv_backend_pkg::*;
(
  input  logic     alu_uop_valid,
  input  alu_rs_t  alu_uop,
  output logic     result_valid,
  output alu2rob_t result
);

  logic                    opcode_ok;
  logic                    sew_ok;
  logic [31:0]             elem;
  logic [`VLENB_CHUNK-1:0] w_data;

  // one element, operands zero-extended to 32 bits
  function automatic logic [31:0] elem_op(alu_opcode_e op, logic [31:0] a, logic [31:0] b,
                                          int unsigned width);
    logic [31:0] mask;
    logic [4:0]  shamt;
    mask  = (width >= 32) ? '1 : ((32'd1 << width) - 32'd1);
    // shift amount uses the low log2(sew) bits only
    shamt = b[4:0] & 5'(width - 1);
    case (op)
      op_add:  return (a + b) & mask;
      op_sub:  return (a - b) & mask;
      op_and:  return a & b;
      op_or:   return a | b;
      op_xor:  return a ^ b;
      op_sll:  return (a << shamt) & mask;
      op_srl:  return a >> shamt;
      op_minu: return (a < b) ? a : b;
      op_maxu: return (a > b) ? a : b;
      default: return '0;
    endcase
  endfunction

  // legality decode
  always_comb begin
    case (alu_uop.opcode)
      op_add, op_sub, op_and, op_or, op_xor,
      op_sll, op_srl, op_minu, op_maxu: opcode_ok = 1'b1;
      default:                          opcode_ok = 1'b0;
    endcase
    case (alu_uop.sew)
      sew_e8, sew_e16, sew_e32: sew_ok = 1'b1;
      default:                  sew_ok = 1'b0;
    endcase
  end

  // split into elements and compute each independently
  always_comb begin
    w_data = '0;
    elem   = '0;
    case (alu_uop.sew)
      sew_e8: begin
        for (int i = 0; i < `VLENB_CHUNK / 8; i++) begin
          elem = elem_op(alu_uop.opcode, {24'b0, alu_uop.vs2_data[8*i +: 8]},
                         {24'b0, alu_uop.vs1_data[8*i +: 8]}, 8);
          w_data[8*i +: 8] = elem[7:0];
        end
      end
      sew_e16: begin
        for (int i = 0; i < `VLENB_CHUNK / 16; i++) begin
          elem = elem_op(alu_uop.opcode, {16'b0, alu_uop.vs2_data[16*i +: 16]},
                         {16'b0, alu_uop.vs1_data[16*i +: 16]}, 16);
          w_data[16*i +: 16] = elem[15:0];
        end
      end
      sew_e32: begin
        for (int i = 0; i < `VLENB_CHUNK / 32; i++) begin
          elem = elem_op(alu_uop.opcode, alu_uop.vs2_data[32*i +: 32],
                         alu_uop.vs1_data[32*i +: 32], 32);
          w_data[32*i +: 32] = elem;
        end
      end
      default: w_data = '0;
    endcase
  end

  assign result_valid     = alu_uop_valid && opcode_ok && sew_ok;
  assign result.rob_entry = alu_uop.rob_entry;
  assign result.w_data    = w_data;

  // the decoder upstream only issues defined opcodes
  always_comb begin
    if (alu_uop_valid) begin
      a_legal_opcode: assert final (opcode_ok)
        else $error("ALU unit: illegal opcode %0d, rob_entry=%0d",
                    alu_uop.opcode, alu_uop.rob_entry);
    end
  end

endmodule

// ==== hdl/rvv_backend_alu.sv ====
/*
  ALU execution wrapper
  runs two ALU units on the station's oldest entries,
  pops in order and hands results to the ROB
*/
`timescale 1ns/1ps
`include "rvv_backend_settings.svh"

module rvv_backend_alu
  import rvv_backend_pkg::*;
(
  input  logic                          clk,
  input  logic                          rst_n,
  // station side
  output logic     [`NUM_ALU_UOP-1:0]   pop_ex2rs,
  input  alu_rs_t  [`NUM_ALU_UOP-1:0]   alu_uop_rs2ex,
  input  logic                          fifo_empty_rs2ex,
  input  logic                          fifo_1left_to_empty_rs2ex,
  // ROB side
  output logic     [`NUM_ALU_UOP-1:0]   result_valid_ex2rob,
  output alu2rob_t [`NUM_ALU_UOP-1:0]   result_ex2rob,
  input  logic     [`NUM_ALU_UOP-1:0]   result_ready_rob2alu
);

  logic [`NUM_ALU_UOP-1:0] alu_uop_valid_rs2ex;

  // lane 1 holds a micro-op only with two or more entries in the station
  assign alu_uop_valid_rs2ex[0] = !fifo_empty_rs2ex;
  assign alu_uop_valid_rs2ex[1] = !fifo_empty_rs2ex && !fifo_1left_to_empty_rs2ex;

  // lane 1 retires only together with lane 0, keeps issue in order
  assign pop_ex2rs[0] = alu_uop_valid_rs2ex[0] && result_valid_ex2rob[0] &&
                        result_ready_rob2alu[0];
  assign pop_ex2rs[1] = pop_ex2rs[0] && alu_uop_valid_rs2ex[1] &&
                        result_valid_ex2rob[1] && result_ready_rob2alu[1];

  for (genvar i = 0; i < `NUM_ALU_UOP; i++) begin : g_lane
    rvv_backend_alu_unit u_alu_unit (
      .alu_uop_valid (alu_uop_valid_rs2ex[i]),
      .alu_uop       (alu_uop_rs2ex[i]),
      .result_valid  (result_valid_ex2rob[i]),
      .result        (result_ex2rob[i])
    );

    // a held micro-op must decode, otherwise the station never drains
    a_lane_result_valid: assert property (@(posedge clk) disable iff (!rst_n)
      alu_uop_valid_rs2ex[i] |-> result_valid_ex2rob[i])
      else $error("ALU lane %0d: no valid result for rob_entry=%0d",
                  i, alu_uop_rs2ex[i].rob_entry);
  end

endmodule

// ==== hdl/rvv_backend_alu_top.sv ====
/*
  ALU execution slice top
  reservation station feeding the two-lane ALU wrapper
*/
`timescale 1ns/1ps
`include "rvv_backend_settings.svh"

module rvv_backend_alu_top
  import rvv_backend_pkg::*;
(
  input  logic                          clk,
  input  logic                          rst_n,
  // micro-op push
  input  logic                          uop_valid,
  input  alu_rs_t                       uop,
  output logic                          uop_ready,
  // results to ROB
  output logic     [`NUM_ALU_UOP-1:0]   result_valid,
  output alu2rob_t [`NUM_ALU_UOP-1:0]   result,
  input  logic     [`NUM_ALU_UOP-1:0]   result_ready
);

  alu_rs_t [`NUM_ALU_UOP-1:0] alu_uop_rs2ex;
  logic                       fifo_empty_rs2ex;
  logic                       fifo_1left_to_empty_rs2ex;
  logic    [`NUM_ALU_UOP-1:0] pop_ex2rs;

  rvv_backend_alu_rs u_alu_rs (
    .clk                 (clk),
    .rst_n               (rst_n),
    .push_valid          (uop_valid),
    .push_uop            (uop),
    .push_ready          (uop_ready),
    .uop_out             (alu_uop_rs2ex),
    .fifo_empty          (fifo_empty_rs2ex),
    .fifo_1left_to_empty (fifo_1left_to_empty_rs2ex),
    .pop                 (pop_ex2rs)
  );

  rvv_backend_alu u_alu (
    .clk                       (clk),
    .rst_n                     (rst_n),
    .pop_ex2rs                 (pop_ex2rs),
    .alu_uop_rs2ex             (alu_uop_rs2ex),
    .fifo_empty_rs2ex          (fifo_empty_rs2ex),
    .fifo_1left_to_empty_rs2ex (fifo_1left_to_empty_rs2ex),
    .result_valid_ex2rob       (result_valid),
    .result_ex2rob             (result),
    .result_ready_rob2alu      (result_ready)
  );

endmodule

// ==== testbench/alu_tb_clock.sv ====
/*
  testbench clock and reset
  4 ns clock, reset held low for the first 16 cycles
*/
`timescale 1ns/1ps

module alu_tb_clock (
  output logic clk,
  output logic rst_n
);

  localparam int RESET_CYCLES = 16;

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // release just after an edge, like the other inputs
  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #0.5;
    rst_n = 1'b1;
  end

endmodule

// ==== testbench/alu_tb_ref.svh ====
/*
  ALU testbench helpers
  LCG, reference model of the ALU operations and typed compare tasks
*/
`ifndef ALU_TB_REF_SVH
`define ALU_TB_REF_SVH

// 32-bit LCG, callers use the upper bits
function automatic logic [31:0] lcg_step(input logic [31:0] state);
  return state * 32'd1664525 + 32'd1013904223;
endfunction

// expected result of one micro-op, element by element
function automatic alu2rob_t ref_alu(input alu_rs_t u);
  alu2rob_t    r;
  int unsigned w;
  int unsigned n;
  int unsigned sh;
  logic [31:0] mask;
  logic [31:0] a;
  logic [31:0] b;
  logic [31:0] y;
  case (u.sew)
    sew_e8:  w = 8;
    sew_e16: w = 16;
    default: w = 32;
  endcase
  n    = 32 / w;
  mask = (w == 32) ? 32'hFFFF_FFFF : ((32'd1 << w) - 32'd1);
  r.rob_entry = u.rob_entry;
  r.w_data    = '0;
  for (int unsigned i = 0; i < n; i++) begin
    a  = (u.vs2_data >> (i * w)) & mask;
    b  = (u.vs1_data >> (i * w)) & mask;
    // shift amount is vs1 modulo the element width
    sh = b % w;
    case (u.opcode)
      op_add:  y = a + b;
      op_sub:  y = a + (~b & mask) + 32'd1;
      op_and:  y = a & b;
      op_or:   y = a | b;
      op_xor:  y = a ^ b;
      op_sll:  y = a << sh;
      op_srl:  y = a >> sh;
      op_minu: y = (a <= b) ? a : b;
      default: y = (a >= b) ? a : b;
    endcase
    r.w_data = r.w_data | ((y & mask) << (i * w));
  end
  return r;
endfunction

task automatic report_mismatch(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
  $display("** Error at %0t: %s expected 0x%h got 0x%h", $realtime, name, exp, act);
  stop_run();
endtask

// rob tag first, then the data
task automatic check_result(input string name, input alu2rob_t exp, input alu2rob_t act);
  if (act.rob_entry !== exp.rob_entry)
    report_mismatch({name, ".rob_entry"}, 32'(exp.rob_entry), 32'(act.rob_entry));
  if (act.w_data !== exp.w_data)
    report_mismatch({name, ".w_data"}, exp.w_data, act.w_data);
endtask

task automatic check_bit(input string name, input logic exp, input logic act);
  if (act !== exp)
    report_mismatch(name, 32'(exp), 32'(act));
endtask

`endif

// ==== testbench/alu_tb.sv ====
/*
  ALU execution slice testbench
  pushes directed and random micro-ops, plays the ROB with
  varying ready and checks every result in push order
*/
`timescale 1ns/1ps
`include "rvv_backend_settings.svh"

module alu_tb
  import rvv_backend_pkg::*;
();

  localparam int N_PAT       = 5;
  localparam int N_DIRECTED  = 9 * 3 * N_PAT;
  localparam int N_RANDOM    = 300;
  localparam int N_RAND_RDY  = 200;
  localparam int N_FULL      = `ALU_RS_DEPTH + 1;
  localparam int N_TOTAL     = N_DIRECTED + N_RANDOM + N_RAND_RDY + N_FULL;
  localparam int TIMEOUT_CYC = 40 * N_TOTAL + 200;

  localparam logic [1:0] READY_ALL    = 2'd0;
  localparam logic [1:0] READY_RANDOM = 2'd1;
  localparam logic [1:0] READY_LOW    = 2'd2;

  // carries, borrows, min/max boundaries and shift extremes
  localparam logic [31:0] DIR_VS2 [N_PAT] = '{32'hFFFF_FFFF, 32'h7F80_FF01, 32'h0000_0000,
                                              32'h8421_F00F, 32'h8000_0001};
  localparam logic [31:0] DIR_VS1 [N_PAT] = '{32'h0000_0001, 32'h0181_0FFF, 32'hFFFF_FFFF,
                                              32'h1F0F_0703, 32'h0000_001F};

  logic                            clk;
  logic                            rst_n;
  logic                            uop_valid;
  alu_rs_t                         uop;
  logic                            uop_ready;
  logic     [`NUM_ALU_UOP-1:0]     result_valid;
  alu2rob_t [`NUM_ALU_UOP-1:0]     result;
  logic     [`NUM_ALU_UOP-1:0]     result_ready;

  alu2rob_t                exp_q [$];
  logic [`ROB_ENTRY_W-1:0] next_rob;
  logic [31:0]             stim_state;
  logic [31:0]             ready_state;
  logic [1:0]              ready_mode;
  logic [1:0]              mode_seen;
  logic                    held_valid;
  alu2rob_t                held_res;
  int                      cycle_count;

  alu_tb_clock alu_tb_clock_i (
    .clk   (clk),
    .rst_n (rst_n)
  );

  rvv_backend_alu_top rvv_backend_alu_top_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .uop_valid    (uop_valid),
    .uop          (uop),
    .uop_ready    (uop_ready),
    .result_valid (result_valid),
    .result       (result),
    .result_ready (result_ready)
  );

  task automatic stop_run();
    $display("Testbench failed");
    $fatal(1, "stopped at the first error");
  endtask

  `include "alu_tb_ref.svh"

  function automatic logic [15:0] draw16();
    stim_state = lcg_step(stim_state);
    return stim_state[31:16];
  endfunction

  // hold valid until the station takes the micro-op
  task automatic send_uop(input alu_opcode_e op, input sew_e sew,
                          input logic [31:0] vs2, input logic [31:0] vs1);
    alu_rs_t u;
    u.rob_entry = next_rob;
    u.opcode    = op;
    u.sew       = sew;
    u.vs2_data  = vs2;
    u.vs1_data  = vs1;
    next_rob    = next_rob + 1'b1;
    uop_valid   = 1'b1;
    uop         = u;
    do @(negedge clk); while (uop_ready !== 1'b1);
    exp_q.push_back(ref_alu(u));
    @(posedge clk);
    #0.5;
    uop_valid = 1'b0;
  endtask

  task automatic send_random();
    alu_opcode_e op;
    sew_e        sew;
    logic [15:0] hi;
    logic [15:0] lo;
    logic [31:0] vs2;
    op  = alu_opcode_e'(4'(draw16() % 16'd9));
    sew = sew_e'(2'(draw16() % 16'd3));
    hi  = draw16();
    lo  = draw16();
    vs2 = {hi, lo};
    hi  = draw16();
    lo  = draw16();
    send_uop(op, sew, vs2, {hi, lo});
  endtask

  task automatic wait_drain();
    while (exp_q.size() != 0)
      @(posedge clk);
    #0.5;
  endtask

  // lane 1 only ever counts behind lane 0
  task automatic accept_result(input int lane);
    alu2rob_t exp;
    if (exp_q.size() == 0) begin
      $display("result on lane %0d at %0t with no micro-op outstanding", lane, $realtime);
      stop_run();
    end
    exp = exp_q.pop_front();
    check_result($sformatf("result[%0d]", lane), exp, result[lane]);
  endtask

  // ROB ready pattern from the mode seen at the last edge
  always @(posedge clk) begin
    mode_seen = ready_mode;
    #0.5;
    case (mode_seen)
      READY_RANDOM: begin
        ready_state  = lcg_step(ready_state);
        result_ready = ready_state[31:30];
      end
      READY_LOW: result_ready = 2'b00;
      default:   result_ready = 2'b11;
    endcase
  end

  // ROB model and scoreboard sampled mid-cycle
  always @(negedge clk) begin
    if (rst_n) begin
      if (held_valid) begin
        check_bit("result_valid[0]", 1'b1, result_valid[0]);
        check_result("result[0]", held_res, result[0]);
      end
      if (result_valid[1])
        check_bit("result_valid[0]", 1'b1, result_valid[0]);
      if (result_valid[0] && result_ready[0]) begin
        accept_result(0);
        if (result_valid[1] && result_ready[1])
          accept_result(1);
      end
      held_valid = result_valid[0] && !result_ready[0];
      held_res   = result[0];
    end
  end

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYC) begin
      $display("timeout after %0d cycles, pipeline stalled with %0d results outstanding",
               cycle_count, exp_q.size());
      stop_run();
    end
  end

  initial begin
    $timeformat(-9, 1, " ns", 10);
    uop_valid    = 1'b0;
    uop          = '0;
    result_ready = 2'b00;
    ready_mode   = READY_ALL;
    mode_seen    = READY_ALL;
    next_rob     = '0;
    stim_state   = 32'd65;
    ready_state  = 32'd65;
    held_valid   = 1'b0;
    held_res     = '0;
    cycle_count  = 0;

    wait (rst_n === 1'b1);
    @(negedge clk);
    check_bit("uop_ready", 1'b1, uop_ready);
    check_bit("result_valid[0]", 1'b0, result_valid[0]);
    check_bit("result_valid[1]", 1'b0, result_valid[1]);
    @(posedge clk);
    #0.5;

    // every opcode at every element width
    for (int s = 0; s < 3; s++)
      for (int o = 0; o < 9; o++)
        for (int p = 0; p < N_PAT; p++)
          send_uop(alu_opcode_e'(4'(o)), sew_e'(2'(s)), DIR_VS2[p], DIR_VS1[p]);
    wait_drain();

    repeat (N_RANDOM) send_random();
    wait_drain();

    ready_mode = READY_RANDOM;
    repeat (N_RAND_RDY) send_random();
    wait_drain();

    // fill the station with the ROB stalled
    ready_mode = READY_LOW;
    @(posedge clk);
    #0.5;
    repeat (`ALU_RS_DEPTH) send_random();
    repeat (4) begin
      @(negedge clk);
      check_bit("uop_ready", 1'b0, uop_ready);
      check_bit("result_valid[0]", 1'b1, result_valid[0]);
      check_bit("result_valid[1]", 1'b1, result_valid[1]);
    end
    @(posedge clk);
    #0.5;
    ready_mode = READY_ALL;
    send_random();
    wait_drain();

    // station idle once every result is taken
    @(negedge clk);
    check_bit("uop_ready", 1'b1, uop_ready);
    check_bit("result_valid[0]", 1'b0, result_valid[0]);
    check_bit("result_valid[1]", 1'b0, result_valid[1]);
    $display("Testbench passed");
    $finish;
  end

endmodule

// ==== verilog.f ====
+incdir+hdl
+incdir+testbench
hdl/rvv_backend_pkg.sv
hdl/rvv_backend_alu_rs.sv
hdl/rvv_backend_alu_unit.sv
hdl/rvv_backend_alu.sv
hdl/rvv_backend_alu_top.sv
testbench/alu_tb_clock.sv
testbench/alu_tb.sv

// ==== Makefile ====
# Verilator build, run and lint for the RVV ALU execution slice

VERILATOR  := verilator
TOP        := alu_tb
RTL_TOP    := rvv_backend_alu_top
FILELIST   := verilog.f
OBJ_DIR    := obj_dir
VFLAGS     := --binary --timing --assert -j 0 --Mdir $(OBJ_DIR)
LINT_FLAGS := --lint-only --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

# a $$fatal in the testbench gives a non-zero exit status
run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
